/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] xword_t;   // data or address word
    typedef logic [4:0]  reg_idx_t; // register index

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011
    } opcode_e;

    // alu funct3 codes
    typedef enum logic [2:0] {
        f3_add = 3'b000, // also sub when funct7[5] set
        f3_sll = 3'b001,
        f3_slt = 3'b010,
        f3_xor = 3'b100,
        f3_srl = 3'b101,
        f3_or  = 3'b110,
        f3_and = 3'b111
    } funct3_e;

    // branch conditions share the funct3 encodings
    localparam funct3_e f3_beq = f3_add;
    localparam funct3_e f3_bne = f3_sll;
    localparam funct3_e f3_blt = f3_xor;
    localparam funct3_e f3_bge = f3_srl;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b // link value for jal and jalr
    } alu_op_e;

    // ecall halts when a7 holds 10
    localparam reg_idx_t halt_reg  = 5'd17;
    localparam xword_t   halt_code = 32'd10;

endpackage

/* verilog/pipe_pkg.sv */
package pipe_pkg;
    import rv_isa_pkg::*;

    // decoded controls, carried from ID/EX down to EX/MEM
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;   // operand b from immediate
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
        logic    is_halt;   // ecall with a7 == 10
        funct3_e funct3;    // branch condition
    } ctrl_t;

    // bubble: nothing written, no bus cycle
    localparam ctrl_t ctrl_nop = '{alu_op: alu_add, funct3: f3_add, default: 1'b0};

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

/* verilog/result_if.sv */
`timescale 1ns/1ns

// pending register result of one stage
interface result_if import rv_isa_pkg::*; ();
    reg_idx_t rd;
    logic     write_en;
    xword_t   value;
    logic     is_load;  // value not valid yet

    modport src (output rd, output write_en, output value, output is_load);
    modport snk (input rd, input write_en, input value, input is_load);

endinterface

/* verilog/reg_file.sv */
`timescale 1ns/1ns

module reg_file import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  reg_idx_t dbg_idx,
    input  logic     write_en,
    input  xword_t   write_data,
    output xword_t   rs1_data,
    output xword_t   rs2_data,
    output xword_t   dbg_data
);
    xword_t regs [32];

    // same-cycle writeback seen by decode
    assign rs1_data = (write_en && rd == rs1 && rs1 != '0) ? write_data : regs[rs1];
    assign rs2_data = (write_en && rd == rs2 && rs2 != '0) ? write_data : regs[rs2];
    assign dbg_data = (write_en && rd == dbg_idx && dbg_idx != '0) ? write_data : regs[dbg_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_en && rd != '0) begin
            regs[rd] <= write_data;
        end
    end

    // writeback must carry a resolved index and value
    assert property (@(posedge clk) disable iff (reset)
        write_en |-> !$isunknown(rd) && !$isunknown(write_data))
        else $error("write to x%0d with unknown data", rd);

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage import rv_isa_pkg::*; #(
    parameter xword_t reset_pc = 32'h0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   freeze,
    input  logic   redirect,
    input  xword_t target,
    output xword_t imem_addr,
    input  xword_t imem_data,
    output xword_t if_inst,
    output xword_t if_pc,
    output logic   if_valid
);
    xword_t pc;

    assign imem_addr = pc; // combinational rom read

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else if (!freeze) begin  // bus wait holds everything
            if (redirect) begin
                pc       <= target;
                if_valid <= 1'b0;      // kill the wrong-path word
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                if_inst  <= imem_data;
                if_pc    <= pc;
                if_valid <= 1'b1;
            end
        end
    end

    // jalr target or reset_pc off word boundary
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  xword_t   if_inst,
    input  xword_t   if_pc,
    input  logic     if_valid,
    input  logic     freeze,
    input  logic     redirect,
    result_if.snk    mem_res,
    result_if.snk    wb_res,
    output logic     stall,
    output ctrl_t    ex_ctrl,
    output xword_t   ex_rs1_val,
    output xword_t   ex_rs2_val,
    output xword_t   ex_imm,
    output xword_t   ex_pc,
    output reg_idx_t ex_rs1,
    output reg_idx_t ex_rs2,
    output reg_idx_t ex_rd,
    input  reg_idx_t dbg_reg_idx,
    output xword_t   dbg_reg_data
);
    opcode_e  opcode;
    reg_idx_t rs1;
    reg_idx_t rs2;
    ctrl_t    ctrl;
    xword_t   imm;
    xword_t   rs1_data;
    xword_t   rs2_data;
    xword_t   x17_val;
    logic     is_ecall;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     load_use;
    logic     x17_pending;
    logic     bubble;
    logic     halt_seen;  // halting ecall already issued

    function automatic alu_op_e alu_sel(input funct3_e f3, input logic alt);
        case (f3)
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_xor:  return alu_xor;
            f3_srl:  return alu_srl;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add; // sltu not supported
        endcase
    endfunction

    assign opcode   = opcode_e'(if_inst[6:0]);
    assign is_ecall = (opcode == opc_system) && (if_inst[31:7] == '0);
    assign rs1      = is_ecall ? halt_reg : if_inst[19:15]; // ecall reads a7
    assign rs2      = if_inst[24:20];
    assign uses_rs1 = (opcode != opc_jal);
    assign uses_rs2 = (opcode == opc_op) || (opcode == opc_store) || (opcode == opc_branch);

    reg_file u_rf (
        .clk        (clk),
        .reset      (reset),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (wb_res.rd),
        .dbg_idx    (dbg_reg_idx),
        .write_en   (wb_res.write_en),
        .write_data (wb_res.value),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dbg_data   (dbg_reg_data)
    );

    // a7 from mem stage, wb covered by write-through
    assign x17_val = (mem_res.write_en && mem_res.rd == halt_reg) ? mem_res.value : rs1_data;

    always_comb begin
        ctrl        = ctrl_nop;
        ctrl.funct3 = funct3_e'(if_inst[14:12]);
        imm         = {{20{if_inst[31]}}, if_inst[31:20]}; // I-type
        case (opcode)
            opc_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_sel(ctrl.funct3, if_inst[30]);
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_sel(ctrl.funct3, 1'b0);
            end
            opc_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            opc_store: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            end
            opc_branch: begin
                ctrl.is_branch = 1'b1;
                imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                       if_inst[11:8], 1'b0};
            end
            opc_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                       if_inst[30:21], 1'b0};
            end
            opc_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
            end
            opc_system: ctrl.is_halt = is_ecall && (x17_val == halt_code);
            default: ;
        endcase
    end

    // load one ahead, or a7 still being produced
    assign load_use = ex_ctrl.mem_read && (ex_rd != '0) &&
                      ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));
    assign x17_pending = is_ecall &&
                         ((ex_ctrl.reg_write && ex_rd == halt_reg) ||
                          (mem_res.write_en && mem_res.is_load && mem_res.rd == halt_reg));
    assign stall  = if_valid && (load_use || x17_pending);
    assign bubble = stall || redirect || !if_valid || halt_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_ctrl   <= ctrl_nop;
            halt_seen <= 1'b0;
        end else if (!freeze) begin
            ex_ctrl    <= bubble ? ctrl_nop : ctrl;
            halt_seen  <= halt_seen || (!bubble && ctrl.is_halt);
            ex_rs1_val <= rs1_data;
            ex_rs2_val <= rs2_data;
            ex_imm     <= imm;
            ex_pc      <= if_pc;
            ex_rs1     <= rs1;
            ex_rs2     <= rs2;
            ex_rd      <= if_inst[11:7];
        end
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     freeze,
    input  ctrl_t    ex_ctrl,
    input  xword_t   ex_rs1_val,
    input  xword_t   ex_rs2_val,
    input  xword_t   ex_imm,
    input  xword_t   ex_pc,
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  reg_idx_t ex_rd,
    result_if.snk    wb_res,
    result_if.src    mem_res,
    output logic     redirect,
    output xword_t   target,
    output ctrl_t    mem_ctrl,
    output xword_t   mem_store_data,
    output xword_t   mem_pc
);
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    xword_t   rs1_fwd;
    xword_t   rs2_fwd;
    xword_t   alu_b;
    xword_t   alu_res;
    xword_t   link;
    logic     taken;

    // newest producer wins, mem before wb
    assign fwd_a = (mem_res.write_en && mem_res.rd != '0 && mem_res.rd == ex_rs1) ? fwd_mem :
                   (wb_res.write_en && wb_res.rd != '0 && wb_res.rd == ex_rs1) ? fwd_wb :
                   fwd_none;
    assign fwd_b = (mem_res.write_en && mem_res.rd != '0 && mem_res.rd == ex_rs2) ? fwd_mem :
                   (wb_res.write_en && wb_res.rd != '0 && wb_res.rd == ex_rs2) ? fwd_wb :
                   fwd_none;

    always_comb begin
        case (fwd_a)
            fwd_mem: rs1_fwd = mem_res.value;
            fwd_wb:  rs1_fwd = wb_res.value;
            default: rs1_fwd = ex_rs1_val;
        endcase
        case (fwd_b)
            fwd_mem: rs2_fwd = mem_res.value;
            fwd_wb:  rs2_fwd = wb_res.value;
            default: rs2_fwd = ex_rs2_val;
        endcase
    end

    assign link  = ex_pc + 32'd4;
    assign alu_b = (ex_ctrl.is_jal || ex_ctrl.is_jalr) ? link :
                   ex_ctrl.alu_src ? ex_imm : rs2_fwd;

    always_comb begin
        case (ex_ctrl.alu_op)
            alu_add: alu_res = rs1_fwd + alu_b;
            alu_sub: alu_res = rs1_fwd - alu_b;
            alu_and: alu_res = rs1_fwd & alu_b;
            alu_or:  alu_res = rs1_fwd | alu_b;
            alu_xor: alu_res = rs1_fwd ^ alu_b;
            alu_slt: alu_res = {31'b0, $signed(rs1_fwd) < $signed(alu_b)};
            alu_sll: alu_res = rs1_fwd << alu_b[4:0];
            alu_srl: alu_res = rs1_fwd >> alu_b[4:0];
            default: alu_res = alu_b;  // pass_b, link
        endcase
        case (ex_ctrl.funct3)
            f3_beq:  taken = (rs1_fwd == rs2_fwd);
            f3_bne:  taken = (rs1_fwd != rs2_fwd);
            f3_blt:  taken = ($signed(rs1_fwd) < $signed(rs2_fwd));
            f3_bge:  taken = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            default: taken = 1'b0;
        endcase
    end

    // predicted not taken, so any taken flow is a redirect
    assign redirect = (ex_ctrl.is_branch && taken) || ex_ctrl.is_jal || ex_ctrl.is_jalr;
    assign target   = ex_ctrl.is_jalr ? ((rs1_fwd + ex_imm) & ~32'd1) : ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ctrl         <= ctrl_nop;
            mem_res.write_en <= 1'b0;
            mem_res.is_load  <= 1'b0;
        end else if (!freeze) begin
            mem_ctrl         <= ex_ctrl;
            mem_res.write_en <= ex_ctrl.reg_write;
            mem_res.is_load  <= ex_ctrl.mem_read;
            mem_res.rd       <= ex_rd;
            mem_res.value    <= alu_res;  // address for lw and sw
            mem_store_data   <= rs2_fwd;
            mem_pc           <= ex_pc;
        end
    end

endmodule

/* verilog/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  ctrl_t  mem_ctrl,
    result_if.snk  mem_res,
    input  xword_t mem_store_data,
    input  xword_t mem_pc,
    output logic   wb_cyc,
    output logic   wb_stb,
    output logic   wb_we,
    output xword_t wb_adr,
    output xword_t wb_dat_o,
    input  xword_t wb_dat_i,
    input  logic   wb_ack,
    output logic   freeze,
    result_if.src  wb_res,
    output logic   is_halted
);
    logic mem_req;

    // classic cycle straight from EX/MEM, held by freeze
    assign mem_req  = mem_ctrl.mem_read || mem_ctrl.mem_write;
    assign wb_cyc   = mem_req;
    assign wb_stb   = mem_req;
    assign wb_we    = mem_ctrl.mem_write;
    assign wb_adr   = mem_res.value;
    assign wb_dat_o = mem_store_data;
    assign freeze   = mem_req && !wb_ack;  // released in the ack cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_res.write_en <= 1'b0;
            wb_res.is_load  <= 1'b0;
            is_halted       <= 1'b0;
        end else if (!freeze) begin
            wb_res.write_en <= mem_res.write_en;
            wb_res.is_load  <= mem_ctrl.mem_read;
            wb_res.rd       <= mem_res.rd;
            wb_res.value    <= mem_ctrl.mem_read ? wb_dat_i : mem_res.value;
            if (mem_ctrl.is_halt)
                is_halted <= 1'b1;  // sticky until reset
        end
    end

    // request must not move or vanish during wait states
    assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we))
        else $error("bus request from pc %h changed before ack", $past(mem_pc));

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top import rv_isa_pkg::*, pipe_pkg::*; #(
    parameter xword_t reset_pc = 32'h0
) (
    input  logic     clk,
    input  logic     reset,
    output xword_t   imem_addr,
    input  xword_t   imem_data,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output xword_t   wb_adr,
    output xword_t   wb_dat_o,
    input  xword_t   wb_dat_i,
    input  logic     wb_ack,
    output logic     is_halted,
    input  reg_idx_t dbg_reg_idx,
    output xword_t   dbg_reg_data
);
    logic     stall;
    logic     freeze;
    logic     redirect;
    xword_t   target;
    xword_t   if_inst;
    xword_t   if_pc;
    logic     if_valid;
    ctrl_t    ex_ctrl;
    xword_t   ex_rs1_val;
    xword_t   ex_rs2_val;
    xword_t   ex_imm;
    xword_t   ex_pc;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    reg_idx_t ex_rd;
    ctrl_t    mem_ctrl;
    xword_t   mem_store_data;
    xword_t   mem_pc;

    result_if mem_res ();  // EX/MEM result
    result_if wb_res ();   // MEM/WB result

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .reset(reset),
        .stall(stall), .freeze(freeze), .redirect(redirect), .target(target),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .if_inst(if_inst), .if_pc(if_pc), .if_valid(if_valid)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset),
        .if_inst(if_inst), .if_pc(if_pc), .if_valid(if_valid),
        .freeze(freeze), .redirect(redirect),
        .mem_res(mem_res.snk), .wb_res(wb_res.snk), .stall(stall),
        .ex_ctrl(ex_ctrl), .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .dbg_reg_idx(dbg_reg_idx), .dbg_reg_data(dbg_reg_data)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .freeze(freeze),
        .ex_ctrl(ex_ctrl), .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .wb_res(wb_res.snk), .mem_res(mem_res.src),
        .redirect(redirect), .target(target),
        .mem_ctrl(mem_ctrl), .mem_store_data(mem_store_data), .mem_pc(mem_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .reset(reset),
        .mem_ctrl(mem_ctrl), .mem_res(mem_res.snk),
        .mem_store_data(mem_store_data), .mem_pc(mem_pc),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .freeze(freeze), .wb_res(wb_res.src), .is_halted(is_halted)
    );

endmodule

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errs;    // errors in the running test
int n_pass;  // tests that ended clean
int n_fail;

task automatic check_xword(input string what, input xword_t got, input xword_t want);
    if (got !== want) begin
        $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
        errs++;
    end
endtask

// store targets as word index
task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t want);
    if (got !== want) begin
        $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        errs++;
    end
endtask

function automatic xword_t enc_r(input funct3_e f3, input logic alt, input reg_idx_t rd,
                                 input reg_idx_t rs1, input reg_idx_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};  // alt picks sub
endfunction

// also used for lw and jalr
function automatic xword_t enc_i(input opcode_e opc, input funct3_e f3, input reg_idx_t rd,
                                 input reg_idx_t rs1, input xword_t imm);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic xword_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1, input xword_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};  // word width
endfunction

function automatic xword_t enc_b(input funct3_e f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                 input xword_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic xword_t enc_j(input reg_idx_t rd, input xword_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

`endif

/* tests/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core import rv_isa_pkg::*; ();

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    xword_t     imem_addr;
    xword_t     imem_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    xword_t     wb_adr;
    xword_t     wb_dat_o;
    xword_t     wb_dat_i = '0;
    logic       wb_ack = 1'b0;
    logic       is_halted;
    reg_idx_t   dbg_reg_idx = '0;
    xword_t     dbg_reg_data;

    integer     seed = 32'h696d;      // wait-state stream
    logic [1:0] wait_left = 2'd0;
    xword_t     rom [64];
    xword_t     dmem [256];
    reg_idx_t   store_log [$];        // word index of every bus write
    xword_t     exp_reg [32];         // reference register file
    xword_t     exp_mem [256];
    reg_idx_t   exp_stores [$];
    int         pc_n;                 // next free rom word
    int         skip_n;               // emitted words the reference does not retire

    `include "tb_checks.svh"

    rv_core_top #(.reset_pc(32'h0)) dut0 (
        .clk(clk), .reset(reset),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .is_halted(is_halted), .dbg_reg_idx(dbg_reg_idx), .dbg_reg_data(dbg_reg_data)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    assign imem_data = rom[imem_addr[7:2]];  // combinational rom

    // every word differs in all address bits
    function automatic xword_t fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {8'hd0, a, ~a, a};
    endfunction

    // wishbone slave with 0 to 3 random wait states
    always @(posedge clk) begin
        if (!reset && wb_cyc !== wb_stb) begin
            $display("wb_cyc and wb_stb differ at %0t ns", $time);
            errs++;
        end
        if (reset) begin
            wb_ack <= 1'b0;
            for (int i = 0; i < 256; i++)
                dmem[i] = fill_word(i);
            store_log.delete();
        end else if (wb_ack) begin
            wb_ack    <= 1'b0;                 // single ack cycle
            wait_left <= 2'($random(seed));
        end else if (wb_cyc && wb_stb) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    dmem[wb_adr[9:2]] = wb_dat_o;
                    store_log.push_back(wb_adr[6:2]);
                end else begin
                    wb_dat_i <= dmem[wb_adr[9:2]];  // valid with ack
                end
            end
        end
    end

    // reference alu per rv32i rules
    function automatic xword_t alu_ref(input funct3_e f3, input logic alt,
                                       input xword_t a, input xword_t b);
        case (f3)
            f3_add:  return alt ? a - b : a + b;
            f3_sll:  return a << b[4:0];
            f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_xor:  return a ^ b;
            f3_srl:  return a >> b[4:0];
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input funct3_e f3, input xword_t a, input xword_t b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);  // bge
        endcase
    endfunction

    // place one word and retire it in the reference
    task automatic emit(input xword_t inst, input reg_idx_t rd, input xword_t value);
        if (skip_n > 0)
            skip_n--;           // flushed or jumped over
        else if (rd != '0)
            exp_reg[rd] = value;
        rom[pc_n] = inst;
        pc_n++;
    endtask

    task automatic r_op(input funct3_e f3, input logic alt, input reg_idx_t rd,
                        input reg_idx_t rs1, input reg_idx_t rs2);
        emit(enc_r(f3, alt, rd, rs1, rs2), rd, alu_ref(f3, alt, exp_reg[rs1], exp_reg[rs2]));
    endtask

    task automatic i_op(input funct3_e f3, input reg_idx_t rd, input reg_idx_t rs1,
                        input xword_t imm);
        xword_t simm;
        simm = {{20{imm[11]}}, imm[11:0]};
        emit(enc_i(opc_op_imm, f3, rd, rs1, imm), rd, alu_ref(f3, 1'b0, exp_reg[rs1], simm));
    endtask

    task automatic load_word(input reg_idx_t rd, input reg_idx_t rs1, input xword_t imm);
        xword_t addr;
        addr = exp_reg[rs1] + imm;
        emit(enc_i(opc_load, f3_slt, rd, rs1, imm), rd, exp_mem[addr[9:2]]);  // 010 is lw
    endtask

    task automatic store_word(input reg_idx_t rs2, input reg_idx_t rs1, input xword_t imm);
        xword_t addr;
        addr = exp_reg[rs1] + imm;
        if (skip_n == 0) begin
            exp_mem[addr[9:2]] = exp_reg[rs2];
            exp_stores.push_back(addr[6:2]);
        end
        emit(enc_s(rs2, rs1, imm), '0, '0);
    endtask

    task automatic branch(input funct3_e f3, input reg_idx_t rs1, input reg_idx_t rs2,
                          input xword_t imm);
        logic live;
        live = (skip_n == 0);
        emit(enc_b(f3, rs1, rs2, imm), '0, '0);
        if (live && br_ref(f3, exp_reg[rs1], exp_reg[rs2]))
            skip_n = imm / 4 - 1;  // forward targets only
    endtask

    task automatic jump(input reg_idx_t rd, input xword_t imm);
        logic   live;
        xword_t link;
        live = (skip_n == 0);
        link = 4 * pc_n + 4;
        emit(enc_j(rd, imm), rd, link);
        if (live)
            skip_n = imm / 4 - 1;
    endtask

    task automatic jump_reg(input reg_idx_t rd, input reg_idx_t rs1, input xword_t imm);
        logic   live;
        xword_t link;
        xword_t tgt;
        live = (skip_n == 0);
        link = 4 * pc_n + 4;
        tgt  = (exp_reg[rs1] + imm) & ~32'd1;  // taken before rd changes
        emit(enc_i(opc_jalr, f3_add, rd, rs1, imm), rd, link);
        if (live)
            skip_n = (tgt - link) / 4;
    endtask

    task automatic env_call();
        logic halts;
        halts = (skip_n == 0) && (exp_reg[17] == 32'd10);
        emit({25'b0, opc_system}, '0, '0);
        if (halts)
            skip_n = 1 << 20;  // nothing younger retires
    endtask

    task automatic halt_prog();
        i_op(f3_add, 17, 0, 10);
        env_call();
    endtask

    task automatic begin_test();
        for (int i = 0; i < 64; i++)
            rom[i] = enc_i(opc_op_imm, f3_add, '0, '0, xword_t'(i));  // nop tagged by slot
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 32; i++)
            exp_reg[i] = '0;
        for (int i = 0; i < 256; i++)
            exp_mem[i] = fill_word(i);
        exp_stores.delete();
        pc_n   = 0;
        skip_n = 0;
        errs   = 0;
    endtask

    // release reset, wait for halt, compare regs, memory and bus writes
    task automatic run_check(input string name);
        int cyc;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (cyc = 0; cyc < 2000 && !is_halted; cyc++)
            @(negedge clk);
        if (!is_halted) begin
            $display("%s: core never halted", name);
            errs++;
        end else begin
            for (int i = 0; i < 32; i++) begin
                @(posedge clk);
                dbg_reg_idx <= reg_idx_t'(i);
                @(negedge clk);
                check_xword($sformatf("%s x%0d", name, i), dbg_reg_data, exp_reg[i]);
                if (!is_halted) begin
                    $display("%s: is_halted dropped before reset", name);
                    errs++;
                end
            end
            for (int i = 0; i < 256; i++)
                check_xword($sformatf("%s mem[%0d]", name, i), dmem[i], exp_mem[i]);
            check_xword({name, " store count"}, xword_t'(store_log.size()),
                        xword_t'(exp_stores.size()));
            for (int i = 0; i < exp_stores.size() && i < store_log.size(); i++)
                check_idx($sformatf("%s store %0d", name, i), store_log[i], exp_stores[i]);
        end
        $display("test %s finished with %0d errors", name, errs);
        if (errs == 0)
            n_pass++;
        else
            n_fail++;
    endtask

    task automatic test_arith();
        begin_test();
        i_op(f3_add, 1, 0, 100);
        i_op(f3_add, 2, 1, -25);        // from mem stage
        r_op(f3_add, 0, 3, 1, 2);       // x1 from wb, x2 from mem
        r_op(f3_add, 1, 4, 3, 1);       // sub
        i_op(f3_xor, 5, 4, 12'h5a5);
        r_op(f3_and, 0, 6, 5, 3);
        r_op(f3_or, 0, 7, 6, 2);
        i_op(f3_and, 8, 7, 12'h0f0);
        i_op(f3_or, 9, 8, -2048);
        r_op(f3_slt, 0, 10, 9, 1);
        i_op(f3_slt, 11, 9, -1);        // negative value below -1
        r_op(f3_sll, 0, 12, 3, 10);
        r_op(f3_srl, 0, 13, 9, 4);
        i_op(f3_add, 0, 1, 5);          // x0 stays zero
        r_op(f3_add, 0, 14, 0, 13);
        halt_prog();
        run_check("arith");
    endtask

    task automatic test_memory();
        begin_test();
        i_op(f3_add, 1, 0, 16);         // base
        i_op(f3_add, 2, 0, -77);
        i_op(f3_add, 3, 0, 12'h123);
        store_word(2, 1, 0);
        store_word(3, 1, 4);
        load_word(4, 1, 0);
        r_op(f3_add, 0, 5, 4, 3);       // load-use
        load_word(6, 1, 4);
        store_word(6, 1, 8);            // load-use on store data
        load_word(7, 1, 8);
        load_word(8, 0, 32);            // untouched fill word
        r_op(f3_xor, 0, 9, 8, 7);
        load_word(10, 1, 12);
        store_word(9, 1, 12);
        load_word(11, 1, 12);
        halt_prog();
        run_check("memory");
    endtask

    task automatic test_branches();
        begin_test();
        i_op(f3_add, 1, 0, 5);
        i_op(f3_add, 2, 0, -3);
        branch(f3_beq, 1, 1, 8);        // taken
        i_op(f3_add, 10, 0, 1);
        branch(f3_bne, 1, 1, 8);        // falls through
        i_op(f3_add, 11, 0, 2);
        branch(f3_blt, 2, 1, 12);       // taken over two
        i_op(f3_add, 12, 0, 3);
        i_op(f3_add, 13, 0, 4);
        branch(f3_bge, 2, 1, 8);
        i_op(f3_add, 14, 0, 5);
        branch(f3_bge, 1, 2, 8);
        i_op(f3_add, 15, 0, 6);
        branch(f3_blt, 1, 2, 8);
        i_op(f3_add, 16, 0, 7);
        branch(f3_bne, 1, 2, 8);
        i_op(f3_add, 18, 0, 8);
        branch(f3_beq, 1, 2, 8);
        i_op(f3_add, 19, 0, 9);
        halt_prog();
        run_check("branches");
    endtask

    task automatic test_jumps();
        begin_test();
        i_op(f3_add, 1, 0, 3);
        jump(5, 12);                    // word 1 to word 4
        i_op(f3_add, 20, 0, 1);
        i_op(f3_add, 21, 0, 1);
        i_op(f3_add, 6, 0, 40);
        jump_reg(7, 6, 5);              // 45 with bit 0 cleared lands on word 11
        for (int k = 22; k < 27; k++)
            i_op(f3_add, k, 0, k);
        i_op(f3_add, 8, 7, 1);          // link forwarded
        jump(0, 8);
        i_op(f3_add, 27, 0, 1);
        r_op(f3_add, 0, 9, 5, 1);
        halt_prog();
        run_check("jumps");
    endtask

    task automatic test_halt();
        begin_test();
        i_op(f3_add, 17, 0, 3);
        env_call();                     // a7 is 3 so it keeps running
        i_op(f3_add, 1, 0, 7);
        store_word(1, 0, 64);
        halt_prog();
        store_word(1, 0, 68);           // younger than the halt
        i_op(f3_add, 2, 0, 9);
        run_check("halt");
    endtask

    initial begin
        test_arith();
        test_memory();
        test_branches();
        test_jumps();
        test_halt();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/result_if.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv_core_top.sv
tests/tb_rv_core.sv
